//--- source/axis_in_pkg.sv
package axis_in_pkg;

   // Stream and CPU data widths
   localparam int TDATA_W = 8;
   localparam int DATA_W = 32;
   localparam int BYTES_PER_WORD = DATA_W / TDATA_W;

   // Byte lane index inside one word
   localparam int LANE_IDX_W = $clog2(BYTES_PER_WORD);

   // 16 FIFO entries
   localparam int FIFO_ADDR_W = 4;

   // CPU word address, four registers
   localparam int REG_ADDR_W = 2;

   typedef logic [TDATA_W-1:0] byte_t;
   typedef logic [DATA_W-1:0] word_t;
   typedef logic [BYTES_PER_WORD-1:0] strb_t;
   typedef logic [FIFO_ADDR_W-1:0] fifo_addr_t;
   // One extra bit so a full FIFO reads as 16
   typedef logic [FIFO_ADDR_W:0] level_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // Register map, word addresses
   localparam reg_addr_t REG_OUT = 2'd0;
   localparam reg_addr_t REG_EMPTY = 2'd1;
   localparam reg_addr_t REG_LAST = 2'd2;
   localparam reg_addr_t REG_LEVEL = 2'd3;

   // Packer states
   // FILL gathers bytes, HOLD waits for the CPU to pop the frame end
   typedef enum logic {
      PACK_FILL,
      PACK_HOLD
   } pack_state_t;

endpackage

//--- source/axis_in_packer.sv
`timescale 1ns/1ns

module axis_in_packer
   import axis_in_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  byte_t tdata,
   input  logic  tvalid,
   input  logic  tlast,
   output logic  tready,
   input  logic  full,
   input  logic  frame_release,
   output logic  push,
   output word_t push_word,
   output strb_t push_strb,
   output logic  push_last
);

   pack_state_t state;
   logic [LANE_IDX_W-1:0] lane_idx;
   word_t part_word;
   strb_t part_strb;

   logic accept;
   logic close_word;
   word_t word_next;
   strb_t strb_next;

   // Stall while a push is in flight too, so a closing byte never
   // meets a FIFO that fills on the same edge
   assign tready = (state == PACK_FILL) && !full && !push;
   assign accept = tvalid && tready;

   // Word closes on the last lane or on the frame end
   assign close_word = (lane_idx == LANE_IDX_W'(BYTES_PER_WORD - 1)) || tlast;

   // Current byte merged into its lane
   always_comb begin
      word_next = part_word;
      word_next[int'(lane_idx)*TDATA_W +: TDATA_W] = tdata;
      strb_next = part_strb | strb_t'(1 << lane_idx);
   end

   // Lane counter, partial word and frame state
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= PACK_FILL;
         lane_idx <= '0;
         part_word <= '0;
         part_strb <= '0;
      end else begin
         if (accept) begin
            if (close_word) begin
               // Start the next word from clean zero lanes
               lane_idx <= '0;
               part_word <= '0;
               part_strb <= '0;
            end else begin
               lane_idx <= lane_idx + 1'b1;
               part_word <= word_next;
               part_strb <= strb_next;
            end
            if (tlast) begin
               state <= PACK_HOLD;
            end
         end else if (state == PACK_HOLD && frame_release) begin
            state <= PACK_FILL;
         end
      end
   end

   // Push request, one cycle after the closing byte
   always_ff @(posedge clk) begin
      if (reset) begin
         push <= 1'b0;
      end else begin
         push <= accept && close_word;
      end
   end

   // Pushed payload, unused upper lanes already zero
   always_ff @(posedge clk) begin
      if (accept && close_word) begin
         push_word <= word_next;
         push_strb <= strb_next;
         push_last <= tlast;
      end
   end

   // FIFO must have room for every push the packer issues
   a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);

endmodule

//--- source/axis_in_word_fifo.sv
`timescale 1ns/1ns

module axis_in_word_fifo
   import axis_in_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   push,
   input  word_t  push_word,
   input  strb_t  push_strb,
   input  logic   push_last,
   input  logic   pop,
   output logic   full,
   output logic   empty,
   output level_t level,
   output word_t  head_word,
   output strb_t  head_strb,
   output logic   head_last
);

   // Storage, one array per field
   word_t mem_word [2**FIFO_ADDR_W];
   strb_t mem_strb [2**FIFO_ADDR_W];
   logic  mem_last [2**FIFO_ADDR_W];

   fifo_addr_t wr_ptr;
   fifo_addr_t rd_ptr;
   level_t     count;

   assign level = count;
   assign empty = (count == '0);
   assign full = (count == level_t'(2**FIFO_ADDR_W));

   // Head entry is shown before any pop
   assign head_word = mem_word[rd_ptr];
   assign head_strb = mem_strb[rd_ptr];
   assign head_last = mem_last[rd_ptr];

   // Write port
   always_ff @(posedge clk) begin
      if (push) begin
         mem_word[wr_ptr] <= push_word;
         mem_strb[wr_ptr] <= push_strb;
         mem_last[wr_ptr] <= push_last;
      end
   end

   // Pointers wrap naturally at 16 entries
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Fill count, unchanged on push and pop together
   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else begin
         case ({push, pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Producer and consumer keep to the flags
   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);
   a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);

endmodule

//--- source/axis_in_regs.sv
`timescale 1ns/1ns

module axis_in_regs
   import axis_in_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      valid,
   input  reg_addr_t address,
   input  word_t     wdata,
   input  strb_t     wstrb,
   output word_t     rdata,
   output logic      ready,
   input  word_t     head_word,
   input  strb_t     head_strb,
   input  logic      head_last,
   input  logic      empty,
   input  level_t    level,
   output logic      pop,
   output logic      frame_release
);

   logic  read_req;
   word_t rdata_next;

   // No write strobes means a read
   assign read_req = valid && (wstrb == '0);

   // Reading OUT consumes the head entry
   assign pop = read_req && (address == REG_OUT) && !empty;

   // Frame end leaving the FIFO lets the packer take the next frame
   assign frame_release = pop && head_last;

   // Read decode
   always_comb begin
      rdata_next = '0;
      if (read_req) begin
         case (address)
            REG_OUT: begin
               if (!empty) begin
                  rdata_next = head_word;
               end
            end
            REG_EMPTY: rdata_next[0] = empty;
            REG_LAST: begin
               // Last flag above the strobe
               if (!empty) begin
                  rdata_next[BYTES_PER_WORD:0] = {head_last, head_strb};
               end
            end
            REG_LEVEL: rdata_next = word_t'(level);
            default: rdata_next = '0;
         endcase
      end
   end

   // Every request completes one cycle later
   always_ff @(posedge clk) begin
      if (reset) begin
         ready <= 1'b0;
      end else begin
         ready <= valid;
      end
   end

   // Read data captured on the same edge as the pop
   always_ff @(posedge clk) begin
      if (valid) begin
         rdata <= rdata_next;
      end
   end

   // Ready lasts one cycle per request
   a_ready_single: assert property (@(posedge clk) disable iff (reset) ready |=> !ready);

   // Write data has no destination
   a_wdata_known: assert property (@(posedge clk) disable iff (reset)
      (valid && wstrb != '0) |-> !$isunknown(wdata));

endmodule

//--- source/axis_in_top.sv
`timescale 1ns/1ns

module axis_in_top
   import axis_in_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   // Byte stream in
   input  byte_t     tdata,
   input  logic      tvalid,
   input  logic      tlast,
   output logic      tready,
   // CPU native bus
   input  logic      valid,
   input  reg_addr_t address,
   input  word_t     wdata,
   input  strb_t     wstrb,
   output word_t     rdata,
   output logic      ready
);

   // Packer to FIFO
   logic  push;
   word_t push_word;
   strb_t push_strb;
   logic  push_last;
   logic  full;

   // FIFO head to register stage
   word_t  head_word;
   strb_t  head_strb;
   logic   head_last;
   logic   empty;
   level_t level;
   logic   pop;

   // Register stage back to packer
   logic frame_release;

   axis_in_packer u_packer (
      .clk           (clk),
      .reset         (reset),
      .tdata         (tdata),
      .tvalid        (tvalid),
      .tlast         (tlast),
      .tready        (tready),
      .full          (full),
      .frame_release (frame_release),
      .push          (push),
      .push_word     (push_word),
      .push_strb     (push_strb),
      .push_last     (push_last)
   );

   axis_in_word_fifo u_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .push_word (push_word),
      .push_strb (push_strb),
      .push_last (push_last),
      .pop       (pop),
      .full      (full),
      .empty     (empty),
      .level     (level),
      .head_word (head_word),
      .head_strb (head_strb),
      .head_last (head_last)
   );

   axis_in_regs u_regs (
      .clk           (clk),
      .reset         (reset),
      .valid         (valid),
      .address       (address),
      .wdata         (wdata),
      .wstrb         (wstrb),
      .rdata         (rdata),
      .ready         (ready),
      .head_word     (head_word),
      .head_strb     (head_strb),
      .head_last     (head_last),
      .empty         (empty),
      .level         (level),
      .pop           (pop),
      .frame_release (frame_release)
   );

endmodule

//--- verif/axis_in_tb.sv
`timescale 1ns/1ns

module axis_in_tb
   import axis_in_pkg::*;
();

   // Bytes sent over all tests
   localparam int TOTAL_BYTES = 103;
   localparam int CLK_PERIOD = 4;

   logic      clk;
   logic      reset;
   byte_t     tdata;
   logic      tvalid;
   logic      tlast;
   logic      tready;
   logic      valid;
   reg_addr_t address;
   word_t     wdata;
   strb_t     wstrb;
   word_t     rdata;
   logic      ready;

   // Reference model of the FIFO contents
   word_t exp_word[$];
   strb_t exp_strb[$];
   logic  exp_last[$];

   int          error_count = 0;
   int          check_count = 0;
   logic [31:0] lfsr_state = 32'h3c56;
   logic        a_sent;

   axis_in_top u_axis_in_top (
      .clk     (clk),
      .reset   (reset),
      .tdata   (tdata),
      .tvalid  (tvalid),
      .tlast   (tlast),
      .tready  (tready),
      .valid   (valid),
      .address (address),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .rdata   (rdata),
      .ready   (ready)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Galois LFSR with taps 32 30 26 25
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
   endfunction

   task automatic random_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = {val[30:0], lfsr_state[0]};
      end
   endtask

   task automatic make_bytes(input int n, output byte_t q[$]);
      logic [31:0] v;
      q = {};
      for (int i = 0; i < n; i++) begin
         random_bits(TDATA_W, v);
         q.push_back(v[TDATA_W-1:0]);
      end
   endtask

   task automatic compare_value(input string name, input word_t got, input word_t exp);
      check_count++;
      assert (got === exp) else begin
         error_count++;
         $display("mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   // Queues the expected words before sending the bytes
   task automatic send_frame(input byte_t bytes[$], input logic gaps);
      word_t       w;
      strb_t       s;
      logic [31:0] gap;
      int          lane;
      w = '0;
      s = '0;
      for (int i = 0; i < bytes.size(); i++) begin
         lane = i % BYTES_PER_WORD;
         w[lane*TDATA_W +: TDATA_W] = bytes[i];
         s[lane] = 1'b1;
         if (lane == BYTES_PER_WORD - 1 || i == bytes.size() - 1) begin
            exp_word.push_back(w);
            exp_strb.push_back(s);
            exp_last.push_back(i == bytes.size() - 1);
            w = '0;
            s = '0;
         end
      end
      for (int i = 0; i < bytes.size(); i++) begin
         if (gaps) begin
            random_bits(2, gap);
            tvalid = 1'b0;
            repeat (gap) begin
               @(posedge clk);
               #1;
            end
         end
         tdata = bytes[i];
         tvalid = 1'b1;
         tlast = (i == bytes.size() - 1);
         // tready comes from registers only and is stable here
         while (!tready) begin
            @(posedge clk);
            #1;
         end
         @(posedge clk);
         #1;
      end
      tvalid = 1'b0;
      tlast = 1'b0;
   endtask

   // One request followed by an idle cycle so ready never repeats
   task automatic cpu_access(input reg_addr_t addr, input word_t data, input strb_t strb,
                             output word_t rd);
      int wait_cycles;
      valid = 1'b1;
      address = addr;
      wdata = data;
      wstrb = strb;
      @(posedge clk);
      #1;
      valid = 1'b0;
      wstrb = '0;
      wait_cycles = 0;
      while (!ready && wait_cycles < 10) begin
         @(posedge clk);
         #1;
         wait_cycles++;
      end
      assert (ready) else begin
         error_count++;
         $display("no ready for the access to register %0d", addr);
      end
      rd = rdata;
      @(posedge clk);
      #1;
   endtask

   task automatic wait_not_empty();
      word_t rd;
      int    polls;
      polls = 0;
      cpu_access(REG_EMPTY, '0, '0, rd);
      while (rd[0] && polls < 200) begin
         cpu_access(REG_EMPTY, '0, '0, rd);
         polls++;
      end
      assert (!rd[0]) else begin
         error_count++;
         $display("FIFO stayed empty while a word was expected");
      end
   endtask

   // Compare strobe, last flag and word of the head entry, then pop it
   task automatic pop_and_compare();
      word_t rd;
      wait_not_empty();
      cpu_access(REG_LAST, '0, '0, rd);
      compare_value("last", rd, word_t'({exp_last.pop_front(), exp_strb.pop_front()}));
      cpu_access(REG_OUT, '0, '0, rd);
      compare_value("out", rd, exp_word.pop_front());
   endtask

   // Pop every expected entry
   task automatic drain_all();
      while (exp_word.size() > 0) begin
         pop_and_compare();
      end
   endtask

   task automatic check_reset_values();
      word_t rd;
      compare_value("tready", word_t'(tready), 32'h1);
      cpu_access(REG_EMPTY, '0, '0, rd);
      compare_value("empty", rd, 32'h1);
      cpu_access(REG_LEVEL, '0, '0, rd);
      compare_value("level", rd, 32'h0);
      cpu_access(REG_LAST, '0, '0, rd);
      compare_value("last", rd, 32'h0);
      cpu_access(REG_OUT, '0, '0, rd);
      compare_value("out", rd, 32'h0);
   endtask

   // Frames of 8 then 1 2 3 5 bytes where the last four close on partial words
   task automatic pack_frames();
      byte_t frame[$];
      int    sizes[5] = '{8, 1, 2, 3, 5};
      foreach (sizes[k]) begin
         make_bytes(sizes[k], frame);
         send_frame(frame, 1'b0);
         drain_all();
      end
   endtask

   task automatic hold_frames();
      byte_t frame_a[$];
      byte_t frame_b[$];
      make_bytes(6, frame_a);
      make_bytes(4, frame_b);
      a_sent = 1'b0;
      fork
         begin
            send_frame(frame_a, 1'b0);
            a_sent = 1'b1;
            send_frame(frame_b, 1'b0);
         end
         begin
            wait (a_sent);
            // Frame B waits at the source until A is popped
            repeat (8) begin
               compare_value("tready", word_t'(tready), 32'h0);
               @(posedge clk);
               #1;
            end
            // Popping the first word of A must not release the frame
            pop_and_compare();
            compare_value("tready", word_t'(tready), 32'h0);
            drain_all();
         end
      join
   endtask

   task automatic fill_fifo();
      byte_t frame[$];
      word_t rd;
      int    polls;
      make_bytes(70, frame);
      fork
         send_frame(frame, 1'b1);
         begin
            polls = 0;
            cpu_access(REG_LEVEL, '0, '0, rd);
            while (rd != 32'd16 && polls < 400) begin
               cpu_access(REG_LEVEL, '0, '0, rd);
               polls++;
            end
            compare_value("level", rd, 32'd16);
            compare_value("tready", word_t'(tready), 32'h0);
            drain_all();
         end
      join
   endtask

   // Writes complete but leave the FIFO alone
   task automatic ignore_writes();
      byte_t       frame[$];
      word_t       rd;
      logic [31:0] v;
      make_bytes(4, frame);
      send_frame(frame, 1'b0);
      wait_not_empty();
      for (int a = 0; a < 4; a++) begin
         random_bits(DATA_W, v);
         cpu_access(reg_addr_t'(a), v, 4'hf, rd);
      end
      cpu_access(REG_LEVEL, '0, '0, rd);
      compare_value("level", rd, 32'h1);
      drain_all();
   endtask

   initial begin
      #((TOTAL_BYTES * 20 + 2000) * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("checks %0d errors %0d", check_count, error_count + 1);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      reset = 1'b1;
      tdata = '0;
      tvalid = 1'b0;
      tlast = 1'b0;
      valid = 1'b0;
      address = '0;
      wdata = '0;
      wstrb = '0;
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      check_reset_values();
      pack_frames();
      hold_frames();
      fill_fifo();
      ignore_writes();
      $display("checks %0d errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- sim.f
source/axis_in_pkg.sv
source/axis_in_packer.sv
source/axis_in_word_fifo.sv
source/axis_in_regs.sv
source/axis_in_top.sv
verif/axis_in_tb.sv

//--- Bender.yml
package:
  name: axis_in

sources:
  - source/axis_in_pkg.sv
  - source/axis_in_packer.sv
  - source/axis_in_word_fifo.sv
  - source/axis_in_regs.sv
  - source/axis_in_top.sv
  - target: test
    files:
      - verif/axis_in_tb.sv
